/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

	//////////////////////////////
	// Major opcodes
	//////////////////////////////
	localparam logic [6:0] OPC_OP     = 7'b0110011;	// Register-register ALU
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;	// Register-immediate ALU
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// funct3 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010;	// LW and SW

	localparam logic [6:0] F7_ALT = 7'b0100000;	// SUB and SRA

	// Field positions, low bit of each field
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB  = 25;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_PASS_B	// LUI
	} alu_op_e;

	typedef logic [31:0] inst_t;

endpackage

/* src/core_cfg_pkg.sv */
package core_cfg_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int PC_W       = 12;	// Byte address into instruction memory

	// Memory depths in words
	localparam int IMEM_WORDS = 512;
	localparam int DMEM_WORDS = 512;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	//////////////////////////////
	// Controller address map
	//////////////////////////////
	localparam int CON_ADDR_W   = 10;
	localparam int CON_IMEM_BIT = 9;	// Set selects instruction memory

	// Source of a decode stage operand
	typedef enum logic [1:0] {
		FWD_NONE,	// Regfile
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_src_e;

endpackage

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                we,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [core_cfg_pkg::XLEN-1:0]       wdata,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr1,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr2,
	output logic [core_cfg_pkg::XLEN-1:0]       rdata1,
	output logic [core_cfg_pkg::XLEN-1:0]       rdata2
);
	import core_cfg_pkg::*;

	logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];	// No storage for x0

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 2**REG_ADDR_W; i++) regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;	// x0 writes dropped
		end
	end

	// Async read, no write-through
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs1,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs2,
	input  logic                                id_uses_rs1,
	input  logic                                id_uses_rs2,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic                                ex_reg_write,
	input  logic                                mem_reg_write,
	input  logic                                wb_reg_write,
	input  logic                                ex_is_load,
	output core_cfg_pkg::fwd_src_e              fwd_a_sel,
	output core_cfg_pkg::fwd_src_e              fwd_b_sel,
	output logic                                load_stall
);
	import core_cfg_pkg::*;

	logic ex_fwd_ok, mem_fwd_ok, wb_fwd_ok;

	// Stage holds a result worth forwarding
	assign ex_fwd_ok  = ex_reg_write && !ex_is_load && (ex_rd != '0);	// Load data not ready
	assign mem_fwd_ok = mem_reg_write && (mem_rd != '0);
	assign wb_fwd_ok  = wb_reg_write && (wb_rd != '0);

	// Youngest match wins
	function automatic fwd_src_e pick_src(input logic uses,
			input logic [REG_ADDR_W-1:0] rs);
		if (!uses)
			return FWD_NONE;
		else if (ex_fwd_ok && rs == ex_rd)
			return FWD_EX;
		else if (mem_fwd_ok && rs == mem_rd)
			return FWD_MEM;
		else if (wb_fwd_ok && rs == wb_rd)
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a_sel = pick_src(id_uses_rs1, id_rs1);
		fwd_b_sel = pick_src(id_uses_rs2, id_rs2);
	end

	// Load in EX feeding the instruction in ID
	assign load_stall = ex_is_load && (ex_rd != '0) &&
		((id_uses_rs1 && id_rs1 == ex_rd) || (id_uses_rs2 && id_rs2 == ex_rd));

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             run,		// Low parks the PC at 0
	input  logic                             load_stall,
	input  logic                             imem_we,	// Controller write
	input  logic [core_cfg_pkg::IMEM_AW-1:0] imem_addr,
	input  logic [core_cfg_pkg::XLEN-1:0]    imem_wdata,
	output rv_isa_pkg::inst_t                id_inst,
	output logic                             id_valid
);
	import core_cfg_pkg::*;

	logic [PC_W-1:0] pc;
	logic [XLEN-1:0] imem [IMEM_WORDS];
	logic [XLEN-1:0] if_inst;

	//////////////////////////////
	// Instruction memory
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (imem_we) imem[imem_addr] <= imem_wdata;
	end

	assign if_inst = imem[pc[IMEM_AW+1:2]];	// Word index, async read

	// PC and valid bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			id_valid <= 1'b0;
		end else if (!run) begin
			pc       <= '0;		// Idle while a program loads
			id_valid <= 1'b0;	// Bubbles drain the pipe
		end else if (!load_stall) begin
			pc       <= pc + PC_W'(4);
			id_valid <= 1'b1;
		end
	end

	// IF/ID instruction word
	// Held on a load-use stall
	always_ff @(posedge clk) begin
		if (run && !load_stall) id_inst <= if_inst;
	end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  rv_isa_pkg::inst_t                   id_inst,
	input  logic                                id_valid,
	input  logic                                load_stall,
	input  core_cfg_pkg::fwd_src_e              fwd_a_sel,
	input  core_cfg_pkg::fwd_src_e              fwd_b_sel,
	input  logic [core_cfg_pkg::XLEN-1:0]       ex_result,	// ALU, same cycle
	input  logic [core_cfg_pkg::XLEN-1:0]       mem_result,	// Load data or ALU
	input  logic [core_cfg_pkg::XLEN-1:0]       wb_data,
	input  logic                                wb_reg_write,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs1,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] id_rs2,
	output logic                                id_uses_rs1,
	output logic                                id_uses_rs2,
	output logic [core_cfg_pkg::XLEN-1:0]       ex_op_a,
	output logic [core_cfg_pkg::XLEN-1:0]       ex_op_b,
	output logic [core_cfg_pkg::XLEN-1:0]       ex_store_data,
	output rv_isa_pkg::alu_op_e                 ex_alu_op,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] ex_rd,
	output logic                                ex_reg_write,
	output logic                                ex_is_load,
	output logic                                ex_is_store
);
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i, imm_s, imm_u, imm;
	logic [XLEN-1:0]       rf_rdata1, rf_rdata2;
	logic [XLEN-1:0]       rs_a_val, rs_b_val;	// After forwarding
	alu_op_e               alu_op;
	logic                  use_imm, reg_write, is_load, is_store;

	// Instruction fields
	assign opcode = id_inst[6:0];
	assign funct3 = id_inst[F3_LSB +: 3];
	assign funct7 = id_inst[F7_LSB +: 7];
	assign rd     = id_inst[RD_LSB +: REG_ADDR_W];
	assign id_rs1 = id_inst[RS1_LSB +: REG_ADDR_W];
	assign id_rs2 = id_inst[RS2_LSB +: REG_ADDR_W];

	// Immediates, all sign extended from bit 31
	assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_u = {id_inst[31:12], 12'b0};

	//////////////////////////////
	// Control decode
	//////////////////////////////
	always_comb begin
		alu_op      = ALU_ADD;	// Also the address add of LW and SW
		imm         = imm_i;
		use_imm     = 1'b0;
		reg_write   = 1'b0;
		is_load     = 1'b0;
		is_store    = 1'b0;
		id_uses_rs1 = 1'b0;
		id_uses_rs2 = 1'b0;
		if (id_valid) begin
			case (opcode)
				OPC_OP: begin
					reg_write   = 1'b1;
					id_uses_rs1 = 1'b1;
					id_uses_rs2 = 1'b1;
					case (funct3)
						F3_ADD_SUB: alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
						F3_SLL:     alu_op = ALU_SLL;
						F3_SLT:     alu_op = ALU_SLT;
						F3_SLTU:    alu_op = ALU_SLTU;
						F3_XOR:     alu_op = ALU_XOR;
						F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						F3_OR:      alu_op = ALU_OR;
						F3_AND:     alu_op = ALU_AND;
					endcase
				end
				OPC_OP_IMM: begin
					reg_write   = 1'b1;
					id_uses_rs1 = 1'b1;
					use_imm     = 1'b1;
					case (funct3)
						F3_SLT:  alu_op = ALU_SLT;
						F3_XOR:  alu_op = ALU_XOR;
						F3_OR:   alu_op = ALU_OR;
						F3_AND:  alu_op = ALU_AND;
						default: alu_op = ALU_ADD;	// ADDI
					endcase
				end
				OPC_LUI: begin
					reg_write = 1'b1;
					use_imm   = 1'b1;
					imm       = imm_u;
					alu_op    = ALU_PASS_B;	// Immediate straight through
				end
				OPC_LOAD: begin
					if (funct3 == F3_WORD) begin	// LW only
						reg_write   = 1'b1;
						is_load     = 1'b1;
						id_uses_rs1 = 1'b1;
						use_imm     = 1'b1;
					end
				end
				OPC_STORE: begin
					if (funct3 == F3_WORD) begin	// SW only
						is_store    = 1'b1;
						id_uses_rs1 = 1'b1;
						id_uses_rs2 = 1'b1;
						use_imm     = 1'b1;
						imm         = imm_s;
					end
				end
				default: ;	// Anything else runs as a NOP
			endcase
		end
	end

	regfile u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (wb_reg_write),
		.waddr (wb_rd),
		.wdata (wb_data),
		.raddr1(id_rs1),
		.raddr2(id_rs2),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2)
	);

	// Operand source named by the hazard unit
	function automatic logic [XLEN-1:0] fwd_pick(input fwd_src_e sel,
			input logic [XLEN-1:0] rf_val);
		case (sel)
			FWD_EX:  return ex_result;
			FWD_MEM: return mem_result;
			FWD_WB:  return wb_data;
			default: return rf_val;
		endcase
	endfunction

	always_comb begin
		rs_a_val = fwd_pick(fwd_a_sel, rf_rdata1);
		rs_b_val = fwd_pick(fwd_b_sel, rf_rdata2);	// Also the SW data
	end

	//////////////////////////////
	// ID/EX register
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_reg_write <= 1'b0;
			ex_is_load   <= 1'b0;
			ex_is_store  <= 1'b0;
		end else begin
			ex_reg_write <= reg_write && !load_stall;	// Stall inserts a bubble
			ex_is_load   <= is_load && !load_stall;
			ex_is_store  <= is_store && !load_stall;
		end
	end

	always_ff @(posedge clk) begin
		ex_op_a       <= rs_a_val;
		ex_op_b       <= use_imm ? imm : rs_b_val;
		ex_store_data <= rs_b_val;
		ex_alu_op     <= alu_op;
		ex_rd         <= rd;
	end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [core_cfg_pkg::XLEN-1:0]       ex_op_a,
	input  logic [core_cfg_pkg::XLEN-1:0]       ex_op_b,
	input  logic [core_cfg_pkg::XLEN-1:0]       ex_store_data,
	input  rv_isa_pkg::alu_op_e                 ex_alu_op,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] ex_rd,
	input  logic                                ex_reg_write,
	input  logic                                ex_is_load,
	input  logic                                ex_is_store,
	output logic [core_cfg_pkg::XLEN-1:0]       ex_result,	// Back to decode too
	output logic [core_cfg_pkg::XLEN-1:0]       mem_alu_result,
	output logic [core_cfg_pkg::XLEN-1:0]       mem_store_data,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] mem_rd,
	output logic                                mem_reg_write,
	output logic                                mem_is_load,
	output logic                                mem_is_store
);
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [4:0] shamt;
	assign shamt = ex_op_b[4:0];	// Shift amount

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (ex_alu_op)
			ALU_ADD:    ex_result = ex_op_a + ex_op_b;
			ALU_SUB:    ex_result = ex_op_a - ex_op_b;
			ALU_AND:    ex_result = ex_op_a & ex_op_b;
			ALU_OR:     ex_result = ex_op_a | ex_op_b;
			ALU_XOR:    ex_result = ex_op_a ^ ex_op_b;
			ALU_SLT:    ex_result = XLEN'($signed(ex_op_a) < $signed(ex_op_b));
			ALU_SLTU:   ex_result = XLEN'(ex_op_a < ex_op_b);
			ALU_SLL:    ex_result = ex_op_a << shamt;
			ALU_SRL:    ex_result = ex_op_a >> shamt;
			ALU_SRA:    ex_result = $signed(ex_op_a) >>> shamt;	// Sign fill
			ALU_PASS_B: ex_result = ex_op_b;
			default:    ex_result = '0;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_reg_write <= 1'b0;
			mem_is_load   <= 1'b0;
			mem_is_store  <= 1'b0;
		end else begin
			mem_reg_write <= ex_reg_write;
			mem_is_load   <= ex_is_load;
			mem_is_store  <= ex_is_store;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu_result <= ex_result;	// Address for LW and SW
		mem_store_data <= ex_store_data;
		mem_rd         <= ex_rd;
	end

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [core_cfg_pkg::XLEN-1:0]       mem_alu_result,
	input  logic [core_cfg_pkg::XLEN-1:0]       mem_store_data,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic                                mem_reg_write,
	input  logic                                mem_is_load,
	input  logic                                mem_is_store,
	input  logic [3:0]                          con_dmem_write,	// Byte enables
	input  logic [core_cfg_pkg::DMEM_AW-1:0]    con_addr,
	input  logic [core_cfg_pkg::XLEN-1:0]       con_in,
	output logic [core_cfg_pkg::XLEN-1:0]       con_out,
	output logic [core_cfg_pkg::XLEN-1:0]       mem_result,
	output logic [core_cfg_pkg::XLEN-1:0]       wb_data,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic                                wb_reg_write
);
	import core_cfg_pkg::*;

	logic [3:0][7:0]     dmem [DMEM_WORDS];	// Byte lanes
	logic [DMEM_AW-1:0]  core_addr;
	logic [XLEN-1:0]     dmem_rdata;

	assign core_addr  = mem_alu_result[DMEM_AW+1:2];	// Word index
	assign dmem_rdata = dmem[core_addr];

	//////////////////////////////
	// Data memory
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (mem_is_store) dmem[core_addr] <= mem_store_data;	// SW, full word
		for (int b = 0; b < 4; b++) begin
			if (con_dmem_write[b]) dmem[con_addr][b] <= con_in[8*b +: 8];
		end
		con_out <= dmem[con_addr];	// Controller read, one cycle late
	end

	// Writeback select
	assign mem_result = mem_is_load ? dmem_rdata : mem_alu_result;

	// MEM/WB register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_reg_write <= 1'b0;
		else
			wb_reg_write <= mem_reg_write;
	end

	always_ff @(posedge clk) begin
		wb_data <= mem_result;
		wb_rd   <= mem_rd;
	end

endmodule

/* src/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                run,		// Low while loading
	input  logic [3:0]                          con_write,
	input  logic [core_cfg_pkg::CON_ADDR_W-1:0] con_addr,
	input  logic [core_cfg_pkg::XLEN-1:0]       con_in,
	output logic [core_cfg_pkg::XLEN-1:0]       con_out		// Data memory readback
);
	import core_cfg_pkg::*;

	// IF/ID
	rv_isa_pkg::inst_t     id_inst;
	logic                  id_valid;

	// Hazard handshake
	logic [REG_ADDR_W-1:0] id_rs1, id_rs2;
	logic                  id_uses_rs1, id_uses_rs2;
	fwd_src_e              fwd_a_sel, fwd_b_sel;
	logic                  load_stall;

	// ID/EX
	logic [XLEN-1:0]       ex_op_a, ex_op_b, ex_store_data, ex_result;
	rv_isa_pkg::alu_op_e   ex_alu_op;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_reg_write, ex_is_load, ex_is_store;

	// EX/MEM
	logic [XLEN-1:0]       mem_alu_result, mem_store_data, mem_result;
	logic [REG_ADDR_W-1:0] mem_rd;
	logic                  mem_reg_write, mem_is_load, mem_is_store;

	// MEM/WB
	logic [XLEN-1:0]       wb_data;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic                  wb_reg_write;

	//////////////////////////////
	// Controller address decode
	//////////////////////////////
	logic       imem_we;
	logic [3:0] con_dmem_write;

	assign imem_we        = |con_write && con_addr[CON_IMEM_BIT];
	assign con_dmem_write = con_write & {4{~con_addr[CON_IMEM_BIT]}};

	fetch_stage u_fetch (
		.*,
		.imem_addr (con_addr[IMEM_AW-1:0]),
		.imem_wdata(con_in)
	);

	decode_stage  u_decode  (.*);
	hazard_unit   u_hazard  (.*);
	execute_stage u_execute (.*);

	mem_wb_stage u_mem_wb (
		.*,
		.con_addr(con_addr[DMEM_AW-1:0])
	);

endmodule

/* test/core_asserts.sv */
`timescale 1ns/1ps

module core_asserts (
	input logic       clk,
	input logic       rst_n,
	input logic       run,
	input logic [3:0] con_write,
	input logic       load_stall,
	input logic       mem_is_store,
	input logic       wb_reg_write
);

	int fail_count;	// Failures seen so far

	// Controller loads only an idle core
	property no_con_write_running;
		@(posedge clk) disable iff (!rst_n) run |-> con_write == '0;
	endproperty

	// One bubble per load-use pair
	property stall_one_cycle;
		@(posedge clk) disable iff (!rst_n) load_stall |=> !load_stall;
	endproperty

	// First cycle out of reset is quiet
	property quiet_after_reset;
		@(posedge clk) $rose(rst_n) |-> !mem_is_store && !wb_reg_write && con_write == '0;
	endproperty

	a_con_idle: assert property (no_con_write_running)
		else begin
			$error("controller write while run is high");
			fail_count++;
		end
	a_stall:    assert property (stall_one_cycle)
		else begin
			$error("load stall held for two cycles");
			fail_count++;
		end
	a_reset:    assert property (quiet_after_reset)
		else begin
			$error("memory or register write in the first cycle after reset");
			fail_count++;
		end

endmodule

bind riscv_core core_asserts u_asserts (.*);

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
	import rv_isa_pkg::*;
	import core_cfg_pkg::*;

	localparam int                    PROG_WORDS = 64;	// Program area padded with NOPs
	localparam int                    FILL_WORDS = 24;	// Result words preset before each run
	localparam int                    MAILBOX    = DMEM_WORDS - 1;	// Done word index
	localparam logic [31:0]           DONE_WORD  = 32'h0000_05A5;
	localparam inst_t                 NOP        = 32'h0000_0013;	// ADDI x0, x0, 0
	localparam int                    RUN_LIMIT  = 400;	// Cycles allowed per program
	localparam logic [CON_ADDR_W-1:0] IMEM_SEL   = CON_ADDR_W'(1) << CON_IMEM_BIT;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  run;
	logic [3:0]            con_write;
	logic [CON_ADDR_W-1:0] con_addr;
	logic [XLEN-1:0]       con_in;
	logic [XLEN-1:0]       con_out;

	int    errors;
	int    tests_run;
	int    tests_failed;
	inst_t prog [$];	// Program under construction

	always #20 clk = ~clk;	// 40 ns period

	riscv_core u_dut (.*);

	//////////////////////////////
	// Instruction encoders
	//////////////////////////////
	function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_t i_type(input logic [6:0] opc, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};	// OP-IMM and LW
	endfunction

	function automatic inst_t s_type(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_t u_type(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OPC_LUI};
	endfunction

	// Byte lanes of new_w replace old_w where enabled
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] be);
		logic [31:0] m;
		m = old_w;
		for (int b = 0; b < 4; b++)
			if (be[b]) m[8*b +: 8] = new_w[8*b +: 8];
		return m;
	endfunction

	// Signed compare from the sign bits
	function automatic logic [31:0] less_signed(input logic [31:0] a, input logic [31:0] b);
		return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
	endfunction

	//////////////////////////////
	// Controller port
	//////////////////////////////
	task automatic write_port(input logic [CON_ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		@(negedge clk);
		con_write = be;
		con_addr  = addr;
		con_in    = data;
		@(negedge clk);
		con_write = '0;
	endtask

	task automatic read_port(input logic [CON_ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		con_addr = addr;
		@(negedge clk);	// Registered read lands one edge later
		data = con_out;
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want) else begin
			$display("Error @ %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_mem(input int slot, input logic [31:0] want, input string what);
		logic [31:0] got;
		read_port(CON_ADDR_W'(slot), got);
		check_word(what, got, want);
	endtask

	task automatic end_test(input string name, input int start);
		tests_run++;
		if (errors > start) begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - start);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	//////////////////////////////
	// Program building and running
	//////////////////////////////
	task automatic emit(input inst_t w);
		prog.push_back(w);
	endtask

	task automatic emit_and_store(input inst_t w, input int slot);
		emit(w);
		emit(s_type(w[11:7], 5'd0, 12'(4 * slot)));	// Result of rd to its slot
	endtask

	// LUI plus ADDI with the upper part rounded for the signed low half
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = value + 32'h800;
		emit(u_type(rd, hi[31:12]));
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, rd, rd, value[11:0]));
	endtask

	task automatic emit_done;
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd31, 5'd0, DONE_WORD[11:0]));
		emit(s_type(5'd31, 5'd0, 12'(4 * MAILBOX)));
	endtask

	// Load with run low and run until the mailbox fills
	task automatic run_program;
		int   cycles;
		logic done;
		for (int i = 0; i < PROG_WORDS; i++)
			write_port(IMEM_SEL | CON_ADDR_W'(i), (i < prog.size()) ? prog[i] : NOP, 4'hF);
		for (int i = 0; i < FILL_WORDS; i++)
			write_port(CON_ADDR_W'(i), 32'hA5A5_0000 | 32'(i), 4'hF);
		write_port(CON_ADDR_W'(MAILBOX), '0, 4'hF);
		@(negedge clk);
		con_addr = CON_ADDR_W'(MAILBOX);
		run      = 1'b1;
		cycles   = 0;
		done     = 1'b0;
		while (!done && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			done = (con_out == DONE_WORD);
		end
		run = 1'b0;
		if (!done) begin
			$display("Timeout: program did not store its done word in %0d cycles", RUN_LIMIT);
			errors++;
		end
		repeat (6) @(negedge clk);	// Pipe drains
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic test_con_port;
		int          start;
		logic [31:0] old_w, new_w, got;
		logic [3:0]  be;
		logic [8:0]  idx;
		start = errors;
		for (int n = 0; n < 8; n++) begin
			idx   = 9'(100 + 7 * n);
			old_w = $urandom;
			new_w = $urandom;
			be    = 4'($urandom);
			write_port(CON_ADDR_W'(idx), old_w, 4'hF);
			read_port(CON_ADDR_W'(idx), got);
			check_word("full word", got, old_w);
			write_port(CON_ADDR_W'(idx), new_w, be);	// Partial lanes
			read_port(CON_ADDR_W'(idx), got);
			check_word("byte merge", got, merge_bytes(old_w, new_w, be));
		end
		end_test("controller port", start);
	endtask

	task automatic test_alu;
		int          start;
		logic [31:0] a, b, ie;
		logic [31:0] want [17];
		logic [11:0] imm;
		logic [4:0]  sh;
		start = errors;
		a   = $urandom;
		b   = $urandom;
		imm = 12'($urandom);
		ie  = {{20{imm[11]}}, imm};
		sh  = b[4:0];	// Shift amount
		prog.delete();
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit_and_store(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd1, 5'd1, 12'd0), 0);
		emit_and_store(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd2, 5'd2, 12'd0), 1);
		emit_and_store(r_type(7'd0, F3_ADD_SUB, 5'd3, 5'd1, 5'd2), 2);
		emit_and_store(r_type(F7_ALT, F3_ADD_SUB, 5'd3, 5'd1, 5'd2), 3);
		emit_and_store(r_type(7'd0, F3_AND, 5'd3, 5'd1, 5'd2), 4);
		emit_and_store(r_type(7'd0, F3_OR, 5'd3, 5'd1, 5'd2), 5);
		emit_and_store(r_type(7'd0, F3_XOR, 5'd3, 5'd1, 5'd2), 6);
		emit_and_store(r_type(7'd0, F3_SLT, 5'd3, 5'd1, 5'd2), 7);
		emit_and_store(r_type(7'd0, F3_SLTU, 5'd3, 5'd1, 5'd2), 8);
		emit_and_store(r_type(7'd0, F3_SLL, 5'd3, 5'd1, 5'd2), 9);
		emit_and_store(r_type(7'd0, F3_SRL_SRA, 5'd3, 5'd1, 5'd2), 10);
		emit_and_store(r_type(F7_ALT, F3_SRL_SRA, 5'd3, 5'd1, 5'd2), 11);
		emit_and_store(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd4, 5'd1, imm), 12);
		emit_and_store(i_type(OPC_OP_IMM, F3_AND, 5'd4, 5'd1, imm), 13);
		emit_and_store(i_type(OPC_OP_IMM, F3_OR, 5'd4, 5'd1, imm), 14);
		emit_and_store(i_type(OPC_OP_IMM, F3_XOR, 5'd4, 5'd1, imm), 15);
		emit_and_store(i_type(OPC_OP_IMM, F3_SLT, 5'd4, 5'd1, imm), 16);
		emit_done();
		run_program();
		want[0]  = a;
		want[1]  = b;
		want[2]  = a + b;
		want[3]  = a - b;
		want[4]  = a & b;
		want[5]  = a | b;
		want[6]  = a ^ b;
		want[7]  = less_signed(a, b);
		want[8]  = {31'b0, a < b};
		want[9]  = a << sh;
		want[10] = a >> sh;
		want[11] = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);	// Sign fill
		want[12] = a + ie;
		want[13] = a & ie;
		want[14] = a | ie;
		want[15] = a ^ ie;
		want[16] = less_signed(a, ie);
		for (int i = 0; i < 17; i++)
			check_mem(i, want[i], $sformatf("ALU slot %0d", i));
		end_test("ALU coverage", start);
	endtask

	task automatic test_forwarding;
		int          start;
		logic [31:0] r5, r6, r7, r8, r9, r10, r11;
		start = errors;
		r5  = $urandom_range(2047, 1);
		r7  = $urandom_range(2047, 1);
		r6  = r5 + 3;
		r8  = r6 + r5;
		r9  = r8 + r7;
		r10 = r9 ^ r8;
		r11 = r8 - r10;
		prog.delete();
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd5, 5'd0, r5[11:0]));
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd6, 5'd5, 12'd3));	// Distance 1
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd7, 5'd0, r7[11:0]));
		emit(r_type(7'd0, F3_ADD_SUB, 5'd8, 5'd6, 5'd5));	// Distances 2 and 3
		emit(r_type(7'd0, F3_ADD_SUB, 5'd9, 5'd8, 5'd7));
		emit(r_type(7'd0, F3_XOR, 5'd10, 5'd9, 5'd8));
		emit(r_type(F7_ALT, F3_ADD_SUB, 5'd11, 5'd8, 5'd10));	// x8 from WB
		for (int i = 0; i < 7; i++)
			emit(s_type(5'(5 + i), 5'd0, 12'(4 * i)));
		emit_done();
		run_program();
		check_mem(0, r5, "x5");
		check_mem(1, r6, "x6");
		check_mem(2, r7, "x7");
		check_mem(3, r8, "x8");
		check_mem(4, r9, "x9");
		check_mem(5, r10, "x10");
		check_mem(6, r11, "x11");
		end_test("forwarding", start);
	endtask

	task automatic test_load_use;
		int          start;
		logic [31:0] k;
		start = errors;
		k = $urandom;
		prog.delete();
		load_const(5'd12, k);
		emit(s_type(5'd12, 5'd0, 12'h020));	// Word 8
		emit(i_type(OPC_LOAD, F3_WORD, 5'd13, 5'd0, 12'h020));
		emit(r_type(7'd0, F3_ADD_SUB, 5'd14, 5'd13, 5'd12));	// Stalls one cycle
		emit(s_type(5'd14, 5'd0, 12'h000));
		emit(i_type(OPC_LOAD, F3_WORD, 5'd15, 5'd0, 12'h020));
		emit(s_type(5'd15, 5'd0, 12'h004));	// Load feeds store data
		emit(i_type(OPC_LOAD, F3_WORD, 5'd16, 5'd0, 12'h020));
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd17, 5'd16, 12'd1));
		emit(s_type(5'd17, 5'd0, 12'h008));
		emit_done();
		run_program();
		check_mem(0, k + k, "load then add");
		check_mem(1, k, "load then store");
		check_mem(2, k + 1, "load then addi");
		check_mem(8, k, "stored word");
		end_test("load-use", start);
	endtask

	task automatic test_reg_zero;
		int          start;
		logic [31:0] k;
		start = errors;
		k = $urandom_range(2047, 1);
		prog.delete();
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd123));
		emit(i_type(OPC_OP_IMM, F3_ADD_SUB, 5'd18, 5'd0, k[11:0]));
		emit(r_type(7'd0, F3_ADD_SUB, 5'd0, 5'd18, 5'd18));
		emit(s_type(5'd0, 5'd0, 12'h000));	// x0 right after a write to it
		emit(r_type(7'd0, F3_ADD_SUB, 5'd19, 5'd0, 5'd18));
		emit(s_type(5'd19, 5'd0, 12'h004));
		emit_done();
		run_program();
		check_mem(0, 32'h0, "stored x0");
		check_mem(1, k, "x0 plus x18");
		end_test("register zero", start);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		void'($urandom(60));
		rst_n        = 1'b0;
		run          = 1'b0;
		con_write    = '0;
		con_addr     = '0;
		con_in       = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		test_con_port();
		test_alu();
		test_forwarding();
		test_load_use();
		test_reg_zero();
		if (u_dut.u_asserts.fail_count != 0)
			$display("Bound assertions failed %0d times", u_dut.u_asserts.fail_count);
		errors += u_dut.u_asserts.fail_count;
		$display("Summary: %0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* sources.f */
src/rv_isa_pkg.sv
src/core_cfg_pkg.sv
src/regfile.sv
src/hazard_unit.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/riscv_core.sv
test/core_asserts.sv
test/core_tb.sv
